// File: fifo_flags.f
hdl/fifo_pkg.sv
hdl/fifo_storage.sv
hdl/fifo_ctrl.sv
hdl/fifo_monitor.sv
hdl/fifo_top.sv
tests/tb_fifo_top.sv

// File: Makefile
# Verilator build and run for the FIFO testbench

SIM      = verilator
VFLAGS   = --binary --timing --assert
TOP      = tb_fifo_top
FILELIST = fifo_flags.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, scan the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_fifo_top.sv
////////////////////////////////////////////////////////////////////////////
// FIFO testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_fifo_top
  import fifo_pkg::*;
();

  localparam int PERIOD      = 40;
  localparam int WAIT_MAX    = 20;
  localparam int RAND_CYCLES = 200;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         push_valid;
  data_t        push_data;
  logic         push_ready;
  logic         pop_ready;
  logic         pop_valid;
  data_t        pop_data;
  fifo_status_t status;
  chk_report_t  report;

  // Words accepted by the DUT and not yet popped
  data_t ref_q [$];
  int    seed;
  int    errors;
  int    checks;
  int    tests;

  fifo_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .status     (status),
    .report     (report)
  );

  initial begin
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_of_test(input string name, input int start_err);
    tests++;
    $display("%-20s finished with %0d errors", name, errors - start_err);
  endtask

  task automatic verify_idle(input string name);
    compare({name, " pop_valid"}, 0, 32'(pop_valid));
    compare({name, " empty"}, 1, 32'(status.empty));
    compare({name, " full"}, 0, 32'(status.full));
    compare({name, " items"}, 0, 32'(status.items));
    compare({name, " slots"}, DEPTH, 32'(status.slots));
    compare({name, " flagged"}, 0, 32'(report.flagged));
  endtask

  // Holds reset for 16 cycles, entered and left on a falling edge
  task automatic apply_reset(input string name);
    rst_n      = 1'b0;
    push_valid = 1'b0;
    pop_ready  = 1'b0;
    repeat (16) @(negedge clk);
    compare({name, " ready in reset"}, 0, 32'(push_ready));
    verify_idle({name, " in reset"});
    rst_n = 1'b1;
    ref_q.delete();
    @(negedge clk);
    compare({name, " ready after reset"}, 1, 32'(push_ready));
    verify_idle({name, " after reset"});
  endtask

  task automatic push_word(input string name, input data_t d, output fifo_status_t snap);
    int wait_cnt;
    push_valid = 1'b1;
    push_data  = d;
    wait_cnt   = 0;
    #(PERIOD / 4);
    while (!push_ready && wait_cnt < WAIT_MAX) begin
      @(negedge clk);
      #(PERIOD / 4);
      wait_cnt++;
    end
    if (!push_ready) begin
      $display("ERROR: %s timed out waiting for push_ready", name);
      errors++;
    end else begin
      ref_q.push_back(d);
    end
    // Status as seen just before the edge
    snap = status;
    @(negedge clk);
    push_valid = 1'b0;
  endtask

  task automatic pop_word(input string name);
    int    wait_cnt;
    data_t exp;
    pop_ready = 1'b1;
    wait_cnt  = 0;
    #(PERIOD / 4);
    while (!pop_valid && wait_cnt < WAIT_MAX) begin
      @(negedge clk);
      #(PERIOD / 4);
      wait_cnt++;
    end
    if (!pop_valid) begin
      $display("ERROR: %s timed out waiting for pop_valid", name);
      errors++;
    end else begin
      exp = ref_q.pop_front();
      compare({name, " data"}, 32'(exp), 32'(pop_data));
    end
    @(negedge clk);
    pop_ready = 1'b0;
    // Empty must rise with the last word and not before
    compare({name, " empty"}, 32'(ref_q.size() == 0), 32'(status.empty));
  endtask

  task automatic drain_all(input string name);
    int guard;
    guard = 0;
    while (ref_q.size() > 0 && guard < 4 * DEPTH) begin
      pop_word(name);
      guard++;
    end
    if (ref_q.size() > 0) begin
      $display("ERROR: %s could not drain the FIFO, %0d words left", name, ref_q.size());
      errors++;
    end
    compare({name, " items"}, 0, 32'(status.items));
  endtask

  task automatic reset_state();
    int start_err;
    start_err = errors;
    apply_reset("reset_state");
    end_of_test("reset_state", start_err);
  endtask

  task automatic fill_to_full();
    int           start_err;
    int           k;
    fifo_status_t snap;
    start_err = errors;
    pop_ready = 1'b0;
    for (k = 0; k < DEPTH; k++) begin
      push_word("fill_to_full", data_t'(8'hA0 + k), snap);
      compare("fill_to_full items", k + 1, 32'(status.items));
      compare("fill_to_full slots", DEPTH - k - 1, 32'(status.slots));
      compare("fill_to_full full", 32'(k + 1 == DEPTH), 32'(status.full));
      compare("fill_to_full empty", 0, 32'(status.empty));
      compare("fill_to_full items_next", 32'(snap.items_next), 32'(status.items));
      compare("fill_to_full slots_next", 32'(snap.slots_next), 32'(status.slots));
      compare("fill_to_full full_next", 32'(snap.full_next), 32'(status.full));
      compare("fill_to_full empty_next", 32'(snap.empty_next), 32'(status.empty));
    end
    compare("fill_to_full full", 1, 32'(status.full));
    compare("fill_to_full push_ready", 0, 32'(push_ready));
    end_of_test("fill_to_full", start_err);
  endtask

  task automatic drain_in_order();
    int start_err;
    start_err = errors;
    drain_all("drain_in_order");
    end_of_test("drain_in_order", start_err);
  endtask

  // Empty FIFO and a ready consumer, so the word leaves in the same cycle
  task automatic bypass_word();
    int start_err;
    start_err  = errors;
    pop_ready  = 1'b1;
    push_valid = 1'b1;
    push_data  = 8'h5A;
    #(PERIOD / 4);
    compare("bypass_word push_ready", 1, 32'(push_ready));
    compare("bypass_word pop_valid", 1, 32'(pop_valid));
    compare("bypass_word pop_data", 32'h5A, 32'(pop_data));
    @(negedge clk);
    push_valid = 1'b0;
    pop_ready  = 1'b0;
    compare("bypass_word items", 0, 32'(status.items));
    compare("bypass_word empty", 1, 32'(status.empty));
    end_of_test("bypass_word", start_err);
  endtask

  task automatic random_traffic();
    int    start_err;
    int    i;
    logic  pending;
    logic  stalled;
    data_t held;
    data_t exp;
    start_err = errors;
    i       = 0;
    pending = 1'b0;
    stalled = 1'b0;
    held    = '0;
    while (i < RAND_CYCLES || pending) begin
      if (i >= RAND_CYCLES + WAIT_MAX) begin
        $display("ERROR: random_traffic timed out waiting for a push to be accepted");
        errors++;
        break;
      end
      @(negedge clk);
      // A word once offered stays put until accepted
      if (!pending) begin
        push_valid = (i < RAND_CYCLES) && (($random(seed) & 1) == 1);
        push_data  = data_t'($random(seed));
      end
      pop_ready = (i >= RAND_CYCLES) || (($random(seed) & 1) == 1);
      #(PERIOD / 4);
      if (stalled) begin
        compare("random_traffic stall valid", 1, 32'(pop_valid));
        compare("random_traffic stall data", 32'(held), 32'(pop_data));
      end
      stalled = pop_valid && !pop_ready;
      held    = pop_data;
      if (push_valid && push_ready) begin
        ref_q.push_back(push_data);
      end
      if (pop_valid && pop_ready) begin
        exp = ref_q.pop_front();
        compare("random_traffic data", 32'(exp), 32'(pop_data));
      end
      pending = push_valid && !push_ready;
      i++;
    end
    @(negedge clk);
    push_valid = 1'b0;
    pop_ready  = 1'b0;
    compare("random_traffic flagged", 0, 32'(report.flagged));
    drain_all("random_traffic");
    end_of_test("random_traffic", start_err);
  endtask

  task automatic upstream_violation();
    int           start_err;
    int           k;
    int           wait_cnt;
    fifo_status_t snap;
    start_err = errors;
    pop_ready = 1'b0;
    for (k = 0; k < DEPTH; k++) begin
      push_word("upstream_violation", data_t'(8'hC0 + k), snap);
    end
    compare("upstream_violation push_ready", 0, 32'(push_ready));
    // Offer a word to the full FIFO, then withdraw it while stalled
    push_valid = 1'b1;
    push_data  = 8'hEE;
    @(negedge clk);
    push_valid = 1'b0;
    wait_cnt   = 0;
    while (!report.flagged && wait_cnt < WAIT_MAX) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!report.flagged) begin
      $display("ERROR: upstream_violation timed out waiting for the checker to flag");
      errors++;
    end
    compare("upstream_violation kind", 32'(ERR_PUSH_UNSTABLE), 32'(report.kind));
    repeat (4) @(negedge clk);
    compare("upstream_violation sticky flag", 1, 32'(report.flagged));
    compare("upstream_violation sticky kind", 32'(ERR_PUSH_UNSTABLE), 32'(report.kind));
    apply_reset("upstream_violation");
    end_of_test("upstream_violation", start_err);
  endtask

  initial begin
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    seed       = 31;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    reset_state();
    fill_to_full();
    drain_in_order();
    bypass_word();
    random_traffic();
    upstream_violation();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/fifo_top.sv
////////////////////////////////////////////////////////////////////////////
// FIFO with in-system checker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fifo_top
  import fifo_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         push_valid,
  input  data_t        push_data,
  output logic         push_ready,
  input  logic         pop_ready,
  output logic         pop_valid,
  output data_t        pop_data,
  output fifo_status_t status,
  output chk_report_t  report
);

  // Controller to storage
  logic  wr_en;
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  data_t rd_data;

  fifo_ctrl i_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .wr_en      (wr_en),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr),
    .rd_data    (rd_data),
    .status     (status)
  );

  fifo_storage i_storage (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_ptr  (wr_ptr),
    .wr_data (push_data),
    .rd_ptr  (rd_ptr),
    .rd_data (rd_data)
  );

  // Checker sees only the ports and status
  fifo_monitor i_monitor (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data),
    .status     (status),
    .report     (report)
  );

endmodule

// File: hdl/fifo_monitor.sv
////////////////////////////////////////////////////////////////////////////
// FIFO protocol and data checker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fifo_monitor
  import fifo_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         push_valid,
  input  logic         push_ready,
  input  data_t        push_data,
  input  logic         pop_valid,
  input  logic         pop_ready,
  input  data_t        pop_data,
  input  fifo_status_t status,
  output chk_report_t  report
);

  // Shadow model of the FIFO contents
  count_t   sh_items;
  ptr_t     sh_head;
  ptr_t     sh_tail;
  data_t    ring [DEPTH];

  logic     push_fire;
  logic     pop_fire;
  logic     push_stall_q;
  logic     pop_stall_q;
  data_t    push_data_q;
  data_t    pop_data_q;
  data_t    expect_data;
  logic     flags_bad;
  chk_err_e err;

  assign push_fire = push_valid & push_ready;
  assign pop_fire  = pop_valid & pop_ready;

  // Pass-through word when the shadow is empty
  assign expect_data = (sh_items == '0) ? push_data : ring[sh_head];

  assign flags_bad = (status.items != sh_items) ||
                     (status.slots != count_t'(DEPTH) - sh_items) ||
                     (status.full != (sh_items == count_t'(DEPTH))) ||
                     (status.empty != (sh_items == '0));

  // First match wins when several checks fail together
  always_comb begin
    if (push_stall_q && (!push_valid || push_data != push_data_q)) begin
      err = ERR_PUSH_UNSTABLE;
    end else if (pop_stall_q && (!pop_valid || pop_data != pop_data_q)) begin
      err = ERR_POP_UNSTABLE;
    end else if (status.empty && !push_valid && pop_valid) begin
      err = ERR_EMPTY_POP;
    end else if (flags_bad) begin
      err = ERR_FLAGS;
    end else if (pop_fire && pop_data != expect_data) begin
      err = ERR_DATA;
    end else begin
      err = ERR_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sh_items     <= '0;
      sh_head      <= '0;
      sh_tail      <= '0;
      push_stall_q <= 1'b0;
      pop_stall_q  <= 1'b0;
      report       <= '{flagged: 1'b0, kind: ERR_NONE};
    end else begin
      sh_items <= sh_items + count_t'(push_fire) - count_t'(pop_fire);
      if (push_fire) begin
        sh_tail <= ptr_inc(sh_tail);
      end
      if (pop_fire) begin
        sh_head <= ptr_inc(sh_head);
      end
      push_stall_q <= push_valid & ~push_ready;
      pop_stall_q  <= pop_valid & ~pop_ready;
      // Sticky: keep only the first violation
      if (!report.flagged && err != ERR_NONE) begin
        report.flagged <= 1'b1;
        report.kind    <= err;
      end
    end
  end

  // Shadow ring and stall snapshots
  always_ff @(posedge clk) begin
    if (push_fire) begin
      ring[sh_tail] <= push_data;
    end
    push_data_q <= push_data;
    pop_data_q  <= pop_data;
  end

  a_next_flags: assert property (@(posedge clk) disable iff (!rst_n)
    1'b1 |=> {status.full, status.empty, status.items, status.slots} ==
             $past({status.full_next, status.empty_next, status.items_next,
                    status.slots_next}));

  a_report_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    report.flagged |=> report.flagged && $stable(report.kind));

endmodule

// File: hdl/fifo_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// FIFO pointers, handshake and status
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fifo_ctrl
  import fifo_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         push_valid,
  input  data_t        push_data,
  output logic         push_ready,
  input  logic         pop_ready,
  output logic         pop_valid,
  output data_t        pop_data,
  output logic         wr_en,
  output ptr_t         wr_ptr,
  output ptr_t         rd_ptr,
  input  data_t        rd_data,
  output fifo_status_t status
);

  ptr_t   head;
  ptr_t   tail;
  logic   ready_q;
  logic   full_q;
  logic   empty_q;
  count_t items_q;
  count_t slots_q;

  logic   push_fire;
  logic   pop_fire;
  logic   bypass;
  logic   do_write;
  logic   do_read;
  logic   full_nx;
  logic   empty_nx;
  count_t items_nx;
  count_t slots_nx;

  // Handshakes
  assign push_ready = ready_q;
  assign push_fire  = push_valid & ready_q;
  assign pop_valid  = ~empty_q | push_fire;
  assign pop_fire   = pop_valid & pop_ready;

  // Empty FIFO with a ready consumer passes the word straight through
  assign bypass   = empty_q & push_fire & pop_ready;
  assign do_write = push_fire & ~bypass;
  assign do_read  = pop_fire & ~empty_q;
  assign pop_data = empty_q ? push_data : rd_data;

  assign wr_en  = do_write;
  assign wr_ptr = tail;
  assign rd_ptr = head;

  // Next-cycle flags
  assign items_nx = items_q + count_t'(do_write) - count_t'(do_read);
  assign slots_nx = count_t'(DEPTH) - items_nx;
  assign full_nx  = (items_nx == count_t'(DEPTH));
  assign empty_nx = (items_nx == '0);

  always_comb begin
    status.full       = full_q;
    status.full_next  = full_nx;
    status.empty      = empty_q;
    status.empty_next = empty_nx;
    status.items      = items_q;
    status.items_next = items_nx;
    status.slots      = slots_q;
    status.slots_next = slots_nx;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head    <= '0;
      tail    <= '0;
      ready_q <= 1'b0;
      full_q  <= 1'b0;
      empty_q <= 1'b1;
      items_q <= '0;
      slots_q <= count_t'(DEPTH);
    end else begin
      if (do_write) begin
        tail <= ptr_inc(tail);
      end
      if (do_read) begin
        head <= ptr_inc(head);
      end
      // Ready tracks not-full from the register stage
      ready_q <= ~full_nx;
      full_q  <= full_nx;
      empty_q <= empty_nx;
      items_q <= items_nx;
      slots_q <= slots_nx;
    end
  end

  a_items_slots_sum: assert property (@(posedge clk) disable iff (!rst_n)
    items_q + slots_q == count_t'(DEPTH));

  a_full_empty_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(full_q && empty_q));

endmodule

// File: hdl/fifo_storage.sv
////////////////////////////////////////////////////////////////////////////
// FIFO register array
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fifo_storage
  import fifo_pkg::*;
(
  input  logic  clk,
  input  logic  wr_en,
  input  ptr_t  wr_ptr,
  input  data_t wr_data,
  input  ptr_t  rd_ptr,
  output data_t rd_data
);

  // One word per entry
  data_t mem [DEPTH];

  // Write port at the tail
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Head entry is visible without a clock edge
  assign rd_data = mem[rd_ptr];

endmodule

// File: hdl/fifo_pkg.sv
////////////////////////////////////////////////////////////////////////////
// FIFO shared definitions
////////////////////////////////////////////////////////////////////////////

package fifo_pkg;

  localparam int DEPTH   = 4;
  localparam int WIDTH   = 8;
  localparam int COUNT_W = 3;
  localparam int PTR_W   = 2;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [PTR_W-1:0]   ptr_t;

  // Registered flags and their next-cycle values
  typedef struct packed {
    logic   full;
    logic   full_next;
    logic   empty;
    logic   empty_next;
    count_t items;
    count_t items_next;
    count_t slots;
    count_t slots_next;
  } fifo_status_t;

  typedef enum logic [2:0] {
    ERR_NONE          = 3'd0,
    ERR_PUSH_UNSTABLE = 3'd1,
    ERR_POP_UNSTABLE  = 3'd2,
    ERR_FLAGS         = 3'd3,
    ERR_DATA          = 3'd4,
    ERR_EMPTY_POP     = 3'd5
  } chk_err_e;

  typedef struct packed {
    logic     flagged;
    chk_err_e kind;
  } chk_report_t;

  // Ring index advance, wraps at DEPTH
  function automatic ptr_t ptr_inc(ptr_t p);
    ptr_inc = (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

endpackage
